//--- hdl/tilemap_pixel_pkg.sv
package tilemap_pixel_pkg;

	////////////////////
	// Data widths
	////////////////////

	// Colour attribute carried with every pixel
	localparam int color_w = 8;

	// Pixel code, 7 is the transparent code
	localparam int dot_w = 3;

	localparam int pri_w = 3;

	// Four pixels per tile row
	localparam int plane_w = 4;

	////////////////////
	// Pixel and tile types
	////////////////////

	// Pixel passed from layer to layer and on to the output link
	typedef struct packed {
		logic [pri_w-1:0]   pri;
		logic [color_w-1:0] color;
		logic [dot_w-1:0]   dot;
	} pixel_t;

	// One layer's share of a tile group
	typedef struct packed {
		logic [color_w-1:0] attr;
		logic [plane_w-1:0] plane0;
		logic [plane_w-1:0] plane1;
		logic [plane_w-1:0] plane2;
	} layer_tile_t;

	// Everything needed to draw four pixels of both layers
	typedef struct packed {
		layer_tile_t layer_a;
		layer_tile_t layer_b;
		logic        flip;
		pixel_t      backdrop;
	} tile_group_t;

endpackage

//--- hdl/tilemap_ctrl_pkg.sv
package tilemap_ctrl_pkg;

	////////////////////
	// Handshake control
	////////////////////

	// Shared by the four-phase receiver and sender
	// idle      nothing in progress
	// hold      own req/ack line is high
	// wait_drop own line dropped, waiting for the partner to drop
	typedef enum logic [1:0] {
		idle      = 2'd0,
		hold      = 2'd1,
		wait_drop = 2'd2
	} hs_state_t;

	////////////////////
	// CPU port
	////////////////////

	// Priority write, valid for a single cycle
	// layer selects A (0) or B (1)
	typedef struct packed {
		logic                               valid;
		logic                               layer;
		logic [tilemap_pixel_pkg::pri_w-1:0] value;
	} pri_write_t;

endpackage

//--- hdl/tile_intake.sv
`timescale 1ns/1ps

module tile_intake (
	input  logic                           CLK_2H,
	input  logic                           rst,

	input  logic                           in_req,
	output logic                           in_ack,
	input  tilemap_pixel_pkg::tile_group_t in_group,

	output tilemap_pixel_pkg::tile_group_t held_group,
	output logic                           group_valid,
	input  logic                           load
);

	import tilemap_pixel_pkg::*;
	import tilemap_ctrl_pkg::*;

	hs_state_t   rx_state;
	tile_group_t buffer;
	pixel_t      cur_backdrop;
	logic        take;

	// Accept only into an empty buffer
	assign take = (rx_state == idle) && in_req && !group_valid;

	////////////////////
	// Four-phase receiver
	////////////////////

	always_ff @(posedge CLK_2H) begin
		if (rst) begin
			rx_state    <= idle;
			in_ack      <= 1'b0;
			group_valid <= 1'b0;
		end else begin
			case (rx_state)
				idle: begin
					if (take) begin
						in_ack      <= 1'b1;
						group_valid <= 1'b1;
						rx_state    <= hold;
					end
				end
				hold: begin
					// Source has dropped req, finish the cycle
					if (!in_req) begin
						in_ack   <= 1'b0;
						rx_state <= idle;
					end
				end
				default: rx_state <= idle;
			endcase

			// Shifters took the group, buffer is free again
			if (load)
				group_valid <= 1'b0;
		end
	end

	////////////////////
	// Group buffer
	////////////////////

	always_ff @(posedge CLK_2H) begin
		if (take)
			buffer <= in_group;
		// Backdrop of the group now in the shifters
		if (load)
			cur_backdrop <= buffer.backdrop;
	end

	// Tiles of the waiting group, backdrop of the shifting group.
	// The shifters copy tiles on load, while layer A reads the
	// backdrop continuously, so the next group may overwrite the buffer.
	always_comb begin
		held_group          = buffer;
		held_group.backdrop = cur_backdrop;
	end

	// New group only after the previous one was handed to the shifters
	ack_only_when_empty: assert property (@(posedge CLK_2H) disable iff (rst)
		$rose(in_ack) |-> $past(!group_valid));

endmodule

//--- hdl/layer_shifter.sv
`timescale 1ns/1ps

module layer_shifter #(
	parameter bit                               layer_id       = 1'b0,
	parameter logic [tilemap_pixel_pkg::pri_w-1:0] reset_priority = 3'd2
) (
	input  logic                           CLK_2H,
	input  logic                           rst,

	input  tilemap_ctrl_pkg::pri_write_t   pri_wr,

	input  tilemap_pixel_pkg::layer_tile_t tile,
	input  logic                           flip,

	input  logic                           load,
	input  logic                           shift,

	input  tilemap_pixel_pkg::pixel_t      below,
	output tilemap_pixel_pkg::pixel_t      merged
);

	import tilemap_pixel_pkg::*;

	logic [pri_w-1:0]   pri_reg;
	logic [pri_w-1:0]   work_pri;
	logic [color_w-1:0] attr;
	logic [plane_w-1:0] plane0;
	logic [plane_w-1:0] plane1;
	logic [plane_w-1:0] plane2;
	logic               flip_q;
	logic [dot_w-1:0]   dot;

	////////////////////
	// CPU priority
	////////////////////

	always_ff @(posedge CLK_2H) begin
		if (rst) begin
			pri_reg <= reset_priority;
		end else if (pri_wr.valid && (pri_wr.layer == layer_id)) begin
			pri_reg <= pri_wr.value;
		end
	end

	////////////////////
	// Bitplane shifters
	////////////////////

	always_ff @(posedge CLK_2H) begin
		if (load) begin
			// Priority is frozen for the whole group
			work_pri <= pri_reg;
			attr     <= tile.attr;
			plane0   <= tile.plane0;
			plane1   <= tile.plane1;
			plane2   <= tile.plane2;
			flip_q   <= flip;
		end else if (shift) begin
			if (flip_q) begin
				plane0 <= plane0 >> 1;
				plane1 <= plane1 >> 1;
				plane2 <= plane2 >> 1;
			end else begin
				plane0 <= plane0 << 1;
				plane1 <= plane1 << 1;
				plane2 <= plane2 << 1;
			end
		end
	end

	// Flipped tiles read out from bit 0
	assign dot = flip_q ? {plane2[0], plane1[0], plane0[0]}
	                    : {plane2[plane_w-1], plane1[plane_w-1], plane0[plane_w-1]};

	////////////////////
	// Priority merge
	////////////////////

	always_comb begin
		merged = below;
		// Ties go to the pixel underneath
		if ((dot != 3'd7) && (work_pri > below.pri)) begin
			merged.pri   = work_pri;
			merged.color = attr;
			merged.dot   = dot;
		end
	end

	// Emitter must never reload mid-shift
	no_load_with_shift: assert property (@(posedge CLK_2H) disable iff (rst)
		!(load && shift));

endmodule

//--- hdl/pixel_emit.sv
`timescale 1ns/1ps

module pixel_emit (
	input  logic                      CLK_2H,
	input  logic                      rst,

	input  logic                      group_valid,
	output logic                      load,
	output logic                      shift,

	input  tilemap_pixel_pkg::pixel_t pixel_in,

	output logic                      out_req,
	input  logic                      out_ack,
	output tilemap_pixel_pkg::pixel_t out_pixel
);

	import tilemap_ctrl_pkg::*;

	hs_state_t  tx_state;
	logic       busy;
	logic [1:0] cnt;
	logic       pixel_ready;

	// Shifter output settled, not in a load or shift cycle
	assign pixel_ready = busy && !load && !shift;

	always_ff @(posedge CLK_2H) begin
		if (rst) begin
			tx_state <= idle;
			out_req  <= 1'b0;
			load     <= 1'b0;
			shift    <= 1'b0;
			busy     <= 1'b0;
			cnt      <= 2'd0;
		end else begin
			load  <= 1'b0;
			shift <= 1'b0;

			// Shifters empty, pull in the waiting group
			if (!busy && group_valid) begin
				load <= 1'b1;
				busy <= 1'b1;
			end

			case (tx_state)
				idle: begin
					if (pixel_ready) begin
						out_req  <= 1'b1;
						tx_state <= hold;
					end
				end
				hold: begin
					if (out_ack) begin
						out_req  <= 1'b0;
						tx_state <= wait_drop;
					end
				end
				wait_drop: begin
					// Sink done, advance to the next pixel
					if (!out_ack) begin
						shift    <= 1'b1;
						cnt      <= cnt + 2'd1;
						tx_state <= idle;
						if (cnt == 2'd3)
							busy <= 1'b0;
					end
				end
				default: tx_state <= idle;
			endcase
		end
	end

	always_ff @(posedge CLK_2H) begin
		if ((tx_state == idle) && pixel_ready)
			out_pixel <= pixel_in;
	end

	pixel_stable_in_req: assert property (@(posedge CLK_2H) disable iff (rst)
		($past(out_req) && out_req) |-> $stable(out_pixel));

endmodule

//--- hdl/tilemap_mixer_top.sv
`timescale 1ns/1ps

module tilemap_mixer_top #(
	parameter logic [tilemap_pixel_pkg::pri_w-1:0] pri_a_reset = 3'd2,
	parameter logic [tilemap_pixel_pkg::pri_w-1:0] pri_b_reset = 3'd4
) (
	input  logic                           CLK_2H,
	input  logic                           rst,

	input  logic                           in_req,
	output logic                           in_ack,
	input  tilemap_pixel_pkg::tile_group_t in_group,

	input  tilemap_ctrl_pkg::pri_write_t   pri_wr,

	output logic                           out_req,
	input  logic                           out_ack,
	output tilemap_pixel_pkg::pixel_t      out_pixel
);

	import tilemap_pixel_pkg::*;

	tile_group_t held_group;
	logic        group_valid;
	logic        load;
	logic        shift;
	pixel_t      merged_a;
	pixel_t      merged_b;

	tile_intake u_intake (
		.CLK_2H      (CLK_2H),
		.rst         (rst),
		.in_req      (in_req),
		.in_ack      (in_ack),
		.in_group    (in_group),
		.held_group  (held_group),
		.group_valid (group_valid),
		.load        (load)
	);

	////////////////////
	// Layer chain
	////////////////////

	// Layer A sits directly on the backdrop
	layer_shifter #(
		.layer_id       (1'b0),
		.reset_priority (pri_a_reset)
	) u_layer_a (
		.CLK_2H (CLK_2H),
		.rst    (rst),
		.pri_wr (pri_wr),
		.tile   (held_group.layer_a),
		.flip   (held_group.flip),
		.load   (load),
		.shift  (shift),
		.below  (held_group.backdrop),
		.merged (merged_a)
	);

	layer_shifter #(
		.layer_id       (1'b1),
		.reset_priority (pri_b_reset)
	) u_layer_b (
		.CLK_2H (CLK_2H),
		.rst    (rst),
		.pri_wr (pri_wr),
		.tile   (held_group.layer_b),
		.flip   (held_group.flip),
		.load   (load),
		.shift  (shift),
		.below  (merged_a),
		.merged (merged_b)
	);

	pixel_emit u_emit (
		.CLK_2H      (CLK_2H),
		.rst         (rst),
		.group_valid (group_valid),
		.load        (load),
		.shift       (shift),
		.pixel_in    (merged_b),
		.out_req     (out_req),
		.out_ack     (out_ack),
		.out_pixel   (out_pixel)
	);

endmodule

//--- bench/tb_model.svh
////////////////////
// Reference model
////////////////////

// Flipped tiles start at bit 0
function automatic logic [dot_w-1:0] tile_dot(input layer_tile_t t, input logic flip,
		input int idx);
	int b;
	b = flip ? idx : (plane_w - 1 - idx);
	return {t.plane2[b], t.plane1[b], t.plane0[b]};
endfunction

// One layer drawn over the pixel underneath it
function automatic pixel_t layer_over(input pixel_t below, input layer_tile_t t,
		input logic flip, input int idx, input logic [pri_w-1:0] pri);
	pixel_t p;
	logic [dot_w-1:0] d;
	d = tile_dot(t, flip, idx);
	p = below;
	// Lower pixel kept unless opaque and strictly above
	if ((d != {dot_w{1'b1}}) && (pri > below.pri)) begin
		p.pri = pri;
		p.color = t.attr;
		p.dot = d;
	end
	return p;
endfunction

function automatic pixel_t expected_pixel(input tile_group_t g, input int idx,
		input logic [pri_w-1:0] pa, input logic [pri_w-1:0] pb);
	pixel_t a;
	a = layer_over(g.backdrop, g.layer_a, g.flip, idx, pa);
	return layer_over(a, g.layer_b, g.flip, idx, pb);
endfunction

////////////////////
// Compare tasks
////////////////////

function automatic string pixel_text(input pixel_t p);
	return $sformatf("pri %0d color %h dot %0d", p.pri, p.color, p.dot);
endfunction

task automatic check_pixel(input string name, input int idx, input pixel_t expected,
		input pixel_t actual);
	if (actual !== expected) begin
		mismatch_errors++;
		$display("mismatch %s pixel %0d: expected %s, actual %s", name, idx,
			pixel_text(expected), pixel_text(actual));
	end
endtask

task automatic check_count(input string name, input int expected, input int actual);
	if (actual != expected) begin
		mismatch_errors++;
		$display("mismatch %s pixel count: expected %0d, actual %0d", name, expected, actual);
	end
endtask

//--- bench/tb_tilemap_mixer.sv
`timescale 1ns/1ps

module tb_tilemap_mixer;

	import tilemap_pixel_pkg::*;
	import tilemap_ctrl_pkg::*;

	// Group modes
	localparam int mode_any = 0;
	localparam int mode_noflip = 1;
	localparam int mode_flip = 2;
	localparam int mode_clear = 3;
	localparam int mode_tie = 4;

	localparam int total_groups = 8 + 12 + 12 + 6 + 6 + 10 + 10 + 10 + 16;
	localparam int cycle_limit = total_groups * 4 * 12 + 200;

	logic        CLK_2H;
	logic        rst;
	logic        in_req;
	logic        in_ack;
	tile_group_t in_group;
	pri_write_t  pri_wr;
	logic        out_req;
	logic        out_ack;
	pixel_t      out_pixel;

	int mismatch_errors = 0;
	int other_errors = 0;
	int rx_count = 0;
	int accepted = 0;
	int sink_min = 0;
	int sink_max = 3;
	int cycles = 0;
	string cur_test = "reset";
	logic [pri_w-1:0] model_pri_a = 3'd2;
	logic [pri_w-1:0] model_pri_b = 3'd4;
	pixel_t exp_q[$];

	`include "tb_model.svh"

	tilemap_mixer_top #(
		.pri_a_reset (3'd2),
		.pri_b_reset (3'd4)
	) uut (
		.CLK_2H    (CLK_2H),
		.rst       (rst),
		.in_req    (in_req),
		.in_ack    (in_ack),
		.in_group  (in_group),
		.pri_wr    (pri_wr),
		.out_req   (out_req),
		.out_ack   (out_ack),
		.out_pixel (out_pixel)
	);

	always #4 CLK_2H = ~CLK_2H;

	// All stimulus and sampling happen just after the rising edge
	task automatic next_cycle();
		@(posedge CLK_2H);
		#1;
	endtask

	function automatic tile_group_t random_group(input int mode);
		tile_group_t g;
		logic [31:0] r;
		r = $urandom;
		g.layer_a = r[19:0];
		r = $urandom;
		g.layer_b = r[19:0];
		r = $urandom;
		g.flip = r[0];
		g.backdrop = r[14:1];
		case (mode)
			mode_noflip: g.flip = 1'b0;
			mode_flip: g.flip = 1'b1;
			mode_clear: begin
				// Every dot reads as 7
				g.layer_a.plane0 = 4'hf;
				g.layer_a.plane1 = 4'hf;
				g.layer_a.plane2 = 4'hf;
				g.layer_b.plane0 = 4'hf;
				g.layer_b.plane1 = 4'hf;
				g.layer_b.plane2 = 4'hf;
				// Backdrop below both layers
				g.backdrop.pri = '0;
			end
			mode_tie: g.backdrop.pri = model_pri_a;
			default: ;
		endcase
		return g;
	endfunction

	task automatic send_group(input tile_group_t g);
		in_group = g;
		in_req = 1'b1;
		next_cycle();
		while (!in_ack)
			next_cycle();
		accepted++;
		// At most one group shifting and one waiting
		if (accepted - rx_count / 4 > 2) begin
			other_errors++;
			$display("%s: in_ack rose while the intake already held a waiting group", cur_test);
		end
		in_req = 1'b0;
		next_cycle();
		while (in_ack)
			next_cycle();
	endtask

	task automatic write_priority(input logic layer, input logic [pri_w-1:0] value);
		pri_wr.valid = 1'b1;
		pri_wr.layer = layer;
		pri_wr.value = value;
		next_cycle();
		pri_wr = '0;
		if (layer)
			model_pri_b = value;
		else
			model_pri_a = value;
	endtask

	task automatic run_groups(input string name, input int n, input int mode, input bit fast);
		int start_rx;
		int gap;
		tile_group_t g;
		cur_test = name;
		start_rx = rx_count;
		for (int i = 0; i < n; i++) begin
			g = random_group(mode);
			for (int k = 0; k < 4; k++)
				exp_q.push_back(expected_pixel(g, k, model_pri_a, model_pri_b));
			send_group(g);
			if (!fast) begin
				gap = $urandom_range(2, 0);
				repeat (gap) next_cycle();
			end
		end
		while (rx_count < start_rx + 4 * n)
			next_cycle();
		// Give a duplicate pixel time to show up
		repeat (20) next_cycle();
		check_count(name, 4 * n, rx_count - start_rx);
	endtask

	////////////////////
	// Pixel sink
	////////////////////

	initial begin : sink
		int delay;
		pixel_t exp_pix;
		out_ack = 1'b0;
		forever begin
			next_cycle();
			if (out_req === 1'b1 && !out_ack) begin
				delay = $urandom_range(sink_max, sink_min);
				repeat (delay) next_cycle();
				out_ack = 1'b1;
				if (exp_q.size() == 0) begin
					other_errors++;
					$display("%s: DUT sent a pixel that no group accounts for", cur_test);
				end else begin
					exp_pix = exp_q.pop_front();
					check_pixel(cur_test, rx_count, exp_pix, out_pixel);
				end
				rx_count++;
				while (out_req)
					next_cycle();
				out_ack = 1'b0;
			end
		end
	end

	initial begin : watchdog
		while (cycles < cycle_limit) begin
			@(posedge CLK_2H);
			cycles++;
		end
		$display("timeout after %0d cycles in %s, DUT stopped responding", cycles, cur_test);
		$display("Result: FAILED");
		$finish;
	end

	////////////////////
	// Test sequence
	////////////////////

	initial begin : main
		logic [31:0] seed_val;
		CLK_2H = 1'b0;
		rst = 1'b1;
		in_req = 1'b0;
		in_group = '0;
		pri_wr = '0;
		seed_val = $urandom(32'h125fcaeb);
		repeat (8) @(posedge CLK_2H);
		#1;
		rst = 1'b0;
		if (in_ack !== 1'b0 || out_req !== 1'b0) begin
			other_errors++;
			$display("in_ack or out_req not low after reset");
		end

		run_groups("reset_priority", 8, mode_any, 1'b0);
		run_groups("flip_clear", 12, mode_noflip, 1'b0);
		run_groups("flip_set", 12, mode_flip, 1'b0);
		run_groups("transparent", 6, mode_clear, 1'b0);

		// Equal priority everywhere lets the backdrop through
		write_priority(1'b0, 3'd5);
		write_priority(1'b1, 3'd5);
		run_groups("equal_priority", 6, mode_tie, 1'b0);

		write_priority(1'b0, 3'd6);
		write_priority(1'b1, 3'd1);
		run_groups("reversed_priority", 10, mode_any, 1'b0);
		write_priority(1'b0, 3'd3);
		write_priority(1'b1, 3'd7);
		run_groups("raised_priority", 10, mode_any, 1'b0);

		sink_min = 6;
		sink_max = 10;
		run_groups("slow_sink", 10, mode_any, 1'b1);
		sink_min = 0;
		sink_max = 3;
		run_groups("back_to_back", 16, mode_any, 1'b1);

		$display("closing: %0d mismatches, %0d other errors", mismatch_errors, other_errors);
		if (mismatch_errors == 0 && other_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- sim.f
+incdir+bench
hdl/tilemap_pixel_pkg.sv
hdl/tilemap_ctrl_pkg.sv
hdl/tile_intake.sv
hdl/layer_shifter.sv
hdl/pixel_emit.sv
hdl/tilemap_mixer_top.sv
bench/tb_tilemap_mixer.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the tilemap mixer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_tilemap_mixer -f sim.f \
	-o tb_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1

grep -q "^Result: PASSED$" sim.log && echo "simulation passed" || {
	echo "simulation failed, see sim.log"
	exit 1
}
